// ==== thor_pkg.sv ====
// Shared widths, opcodes and bus structs for the instruction alignment front end
package thor_pkg;

  // ======================================================================
  // Widths
  // ======================================================================

  // Bytes delivered by one instruction memory fetch
  localparam int FETCH_BYTES = 8;
  // Longest instruction the length decoder can report
  localparam int MAX_INS_BYTES = 8;
  // Width of the queue fill count, roomy enough for any practical depth
  localparam int COUNT_W = 16;

  // ======================================================================
  // Opcodes
  // ======================================================================

  // Only the first byte of an instruction matters to the front end.
  // Rows 0x2x and 0x3x are branches and 0xDx and 0xEx are indexed memory ops,
  // so the named members there just document a few of them
  typedef enum logic [7:0] {
    BRK    = 8'h00, R1     = 8'h01, R2     = 8'h02, R3     = 8'h03,
    ADDI   = 8'h04, SUBFI  = 8'h05, MULI   = 8'h06, CSR    = 8'h07,
    ANDI   = 8'h08, ORI    = 8'h09, XORI   = 8'h0A, ADCI   = 8'h0B,
    SBCFI  = 8'h0C, MULUI  = 8'h0D, SEQI   = 8'h10, SNEI   = 8'h11,
    SLTI   = 8'h12, SGTI   = 8'h13, SLTUI  = 8'h14, SGTUI  = 8'h15,
    JEQZ   = 8'h18, JNEZ   = 8'h19, DJEQZ  = 8'h1A, DJNEZ  = 8'h1B,
    BEQ    = 8'h20, BNE    = 8'h21, BLT    = 8'h22, BGE    = 8'h23,
    DBEQ   = 8'h30, DBNE   = 8'h31, DIVI   = 8'h40, CPUID  = 8'h41,
    DIVIL  = 8'h42, MUX    = 8'h43, ADDIL  = 8'h44, CHKI   = 8'h45,
    MULIL  = 8'h46, SNEIL  = 8'h47, ANDIL  = 8'h48, ORIL   = 8'h49,
    XORIL  = 8'h4A, SEQIL  = 8'h4B, SLTIL  = 8'h4C, SGTIL  = 8'h4D,
    MULUIL = 8'h4E, DIVUI  = 8'h4F, EXI7   = 8'h50, EXI23  = 8'h51,
    EXI41  = 8'h52, EXI55  = 8'h53, F1     = 8'h60, F2     = 8'h61,
    F3     = 8'h62, LDB    = 8'h80, LDBU   = 8'h81, LDW    = 8'h82,
    LDWU   = 8'h83, LDT    = 8'h84, LDTU   = 8'h85, LDO    = 8'h86,
    LDOS   = 8'h87, LEA    = 8'h88, STB    = 8'h90, STW    = 8'h91,
    STT    = 8'h92, STO    = 8'h93, STOS   = 8'h94, CACHE  = 8'h95,
    SYS    = 8'hA0, INT    = 8'hA1, MOV    = 8'hA2, LDBX   = 8'hD0,
    LDOX   = 8'hD6, STBX   = 8'hE0, STOX   = 8'hE3, NOP    = 8'hF0,
    RTS    = 8'hF1, RTE    = 8'hF2, SYNC   = 8'hF3, WFI    = 8'hF4
  } opcode_e;

  // ======================================================================
  // Structs
  // ======================================================================

  // One aligned instruction, opcode in the low byte and unused bytes zero
  typedef struct packed {
    logic [31:0]                  pc;
    logic [3:0]                   len;
    logic [MAX_INS_BYTES*8-1:0]   bits;
  } ins_t;

  // Fetch request, the address is always a multiple of FETCH_BYTES
  typedef struct packed {
    logic [31:0] addr;
  } fetch_req_t;

  // Fetch response, the byte at the request address sits in the low byte
  typedef struct packed {
    logic [FETCH_BYTES*8-1:0] data;
  } fetch_rsp_t;

endpackage

// ==== thor_inslength.sv ====
// Instruction length decoder that maps an opcode byte to a byte count
`timescale 1ns/10ps

module thor_inslength (
  input  thor_pkg::opcode_e opcode,
  output logic [3:0]        len
);
  import thor_pkg::*;

  // Named rows are matched before the wildcard rows, so a listed opcode
  // always wins over its row default
  always_comb begin
    casez (opcode)
      // Two byte forms, the same as the default but listed for clarity
      BRK, NOP, RTS, RTE, EXI7, SYNC, WFI: begin
        len = 4'd2;
      end
      // Register forms with a single source
      R1, MOV, SYS, INT: begin
        len = 4'd4;
      end
      // Short immediate forms
      ADDI, SUBFI, MULI, ANDI, ORI, XORI, ADCI, SBCFI, MULUI,
      SEQI, SNEI, SLTI, SGTI, SLTUI, SGTUI, DIVI, DIVUI, CPUID: begin
        len = 4'd4;
      end
      // Short branches on zero and the 23 bit extension prefix
      JEQZ, JNEZ, DJEQZ, DJNEZ, EXI23, F1: begin
        len = 4'd4;
      end
      // Stack relative load and store fit in four bytes
      LDOS, STOS: begin
        len = 4'd4;
      end
      // Two and three source register forms
      R2, R3, CSR, MUX, F2, F3: begin
        len = 4'd6;
      end
      // Long immediate forms
      ADDIL, MULIL, DIVIL, ANDIL, ORIL, XORIL, SEQIL, SNEIL,
      SLTIL, SGTIL, MULUIL, CHKI, EXI41: begin
        len = 4'd6;
      end
      // Loads and stores with a displacement
      LDB, LDBU, LDW, LDWU, LDT, LDTU, LDO, LEA,
      STB, STW, STT, STO, CACHE: begin
        len = 4'd6;
      end
      // The 55 bit extension prefix is the only eight byte form
      EXI55: begin
        len = 4'd8;
      end
      // Branch rows
      8'h2?, 8'h3?: begin
        len = 4'd6;
      end
      // Indexed memory rows
      8'hD?, 8'hE?: begin
        len = 4'd6;
      end
      default: begin
        len = 4'd2;
      end
    endcase
  end

endmodule

// ==== thor_byte_queue.sv ====
// Circular byte queue that takes fetch words with a start offset and pops whole instructions
`timescale 1ns/10ps

module thor_byte_queue #(
  parameter int QUEUE_BYTES = 16
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         flush,
  input  logic                         push_valid,
  input  logic [63:0]                  push_data,
  input  logic [2:0]                   push_offset,
  input  logic                         pop_valid,
  input  logic [3:0]                   pop_len,
  output logic [thor_pkg::COUNT_W-1:0] count,
  output logic [63:0]                  head
);
  import thor_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_BYTES);

  // Byte storage, the pointers wrap naturally since the depth is a power of two
  logic [7:0]       mem [QUEUE_BYTES];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [3:0]       push_len;
  logic [3:0]       pop_n;
  logic [63:0]      push_shift;

  // A push keeps the bytes from push_offset upward
  assign push_len   = push_valid ? 4'(FETCH_BYTES) - {1'b0, push_offset} : 4'd0;
  assign pop_n      = pop_valid ? pop_len : 4'd0;
  assign push_shift = push_data >> {push_offset, 3'b000};

  // ======================================================================
  // Pointers and fill count
  // ======================================================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      // A flush drops every byte, including any push or pop of this cycle
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(push_len);
      rd_ptr <= rd_ptr + PTR_W'(pop_n);
      count  <= count + COUNT_W'(push_len) - COUNT_W'(pop_n);
    end
  end

  // ======================================================================
  // Storage
  // ======================================================================

  // Up to eight bytes land at the write pointer in one cycle
  always_ff @(posedge clk) begin
    for (int i = 0; i < FETCH_BYTES; i++) begin
      if (!flush && (i < int'(push_len))) begin
        mem[wr_ptr + PTR_W'(i)] <= push_shift[i*8 +: 8];
      end
    end
  end

  // Head window, bytes beyond the fill count read as zero so that an
  // empty queue shows a zero opcode
  always_comb begin
    for (int i = 0; i < FETCH_BYTES; i++) begin
      if (COUNT_W'(i) < count) begin
        head[i*8 +: 8] = mem[rd_ptr + PTR_W'(i)];
      end else begin
        head[i*8 +: 8] = 8'h00;
      end
    end
  end

endmodule

// ==== thor_fetch_ctrl.sv ====
// Fetch sequencer that issues word requests, pushes responses and handles redirects
`timescale 1ns/10ps

module thor_fetch_ctrl #(
  parameter int          QUEUE_BYTES = 16,
  parameter logic [31:0] RESET_PC    = 32'h0
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         redirect_valid,
  input  logic [31:0]                  redirect_pc,
  input  logic                         fetch_rsp_valid,
  input  thor_pkg::fetch_rsp_t         fetch_rsp,
  input  logic [thor_pkg::COUNT_W-1:0] count,
  output logic                         fetch_req_valid,
  output thor_pkg::fetch_req_t         fetch_req,
  output logic                         push_valid,
  output logic [63:0]                  push_data,
  output logic [2:0]                   push_offset,
  output logic                         flush
);
  import thor_pkg::*;

  localparam int FILL_W = COUNT_W + 1;

  logic [31:0]       next_addr;
  logic              outstanding;
  logic              stale;
  logic [2:0]        start_off;
  logic [31:0]       redir_base;
  logic              busy_after;
  logic [FILL_W-1:0] fill_next;
  logic              room;
  logic              issue;
  logic [31:0]       issue_addr;

  // A stale response and any response in a redirect cycle belong to the
  // old stream and never reach the queue
  assign flush       = redirect_valid;
  assign push_valid  = fetch_rsp_valid && !stale && !redirect_valid;
  assign push_data   = fetch_rsp.data;
  assign push_offset = start_off;

  assign redir_base = {redirect_pc[31:3], 3'b000};
  // Still waiting after this edge
  assign busy_after = outstanding && !fetch_rsp_valid;
  // Fill level once this cycle's push lands, pops are ignored to stay safe
  assign fill_next  = FILL_W'(count) + (push_valid ? FILL_W'(FETCH_BYTES - start_off) : '0);
  assign room       = (fill_next + FILL_W'(FETCH_BYTES)) <= FILL_W'(QUEUE_BYTES);

  // The queue is flushed on a redirect, so only the outstanding request
  // can hold the new fetch back
  always_comb begin
    if (redirect_valid) begin
      issue      = !busy_after;
      issue_addr = redir_base;
    end else begin
      issue      = !busy_after && room;
      issue_addr = next_addr;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_req_valid <= 1'b0;
      outstanding     <= 1'b0;
      stale           <= 1'b0;
      next_addr       <= {RESET_PC[31:3], 3'b000};
      start_off       <= RESET_PC[2:0];
    end else begin
      fetch_req_valid <= issue;
      outstanding     <= issue || busy_after;
      // The request still in flight at a redirect is answered with old data
      if (redirect_valid) begin
        stale <= busy_after;
      end else if (fetch_rsp_valid) begin
        stale <= 1'b0;
      end
      if (issue) begin
        next_addr <= issue_addr + 32'(FETCH_BYTES);
      end else if (redirect_valid) begin
        next_addr <= redir_base;
      end
      // Only the first word after a redirect starts part way in
      if (redirect_valid) begin
        start_off <= redirect_pc[2:0];
      end else if (push_valid) begin
        start_off <= 3'd0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      fetch_req.addr <= issue_addr;
    end
  end

endmodule

// ==== thor_ins_extract.sv ====
// Instruction extractor that pops complete instructions from the queue head
`timescale 1ns/10ps

module thor_ins_extract #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         redirect_valid,
  input  logic [31:0]                  redirect_pc,
  input  logic [thor_pkg::COUNT_W-1:0] count,
  input  logic [63:0]                  head,
  output logic                         pop_valid,
  output logic [3:0]                   pop_len,
  output logic                         ins_valid,
  output thor_pkg::ins_t               ins
);
  import thor_pkg::*;

  opcode_e                    opcode;
  logic [3:0]                 dec_len;
  logic                       complete;
  logic [31:0]                pc;
  logic [MAX_INS_BYTES*8-1:0] bits_masked;

  assign opcode = opcode_e'(head[7:0]);

  thor_inslength u_inslength (
    .opcode (opcode),
    .len    (dec_len)
  );

  // An empty queue shows BRK with two bytes needed, so it never pops
  assign complete  = count >= COUNT_W'(dec_len);
  // Nothing from the old stream leaves once a redirect is seen
  assign pop_valid = complete && !redirect_valid;
  assign pop_len   = dec_len;

  // Bytes past the instruction belong to the next one
  always_comb begin
    for (int i = 0; i < MAX_INS_BYTES; i++) begin
      bits_masked[i*8 +: 8] = (i < int'(dec_len)) ? head[i*8 +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ins_valid <= 1'b0;
      pc        <= RESET_PC;
    end else begin
      ins_valid <= pop_valid;
      if (redirect_valid) begin
        pc <= redirect_pc;
      end else if (pop_valid) begin
        pc <= pc + 32'(dec_len);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_valid) begin
      ins.pc   <= pc;
      ins.len  <= dec_len;
      ins.bits <= bits_masked;
    end
  end

endmodule

// ==== thor_align.sv ====
// Instruction alignment front end that turns fetch words into whole instructions
`timescale 1ns/10ps

module thor_align #(
  parameter int          QUEUE_BYTES = 16,
  parameter logic [31:0] RESET_PC    = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 arst_n,
  output logic                 fetch_req_valid,
  output thor_pkg::fetch_req_t fetch_req,
  input  logic                 fetch_rsp_valid,
  input  thor_pkg::fetch_rsp_t fetch_rsp,
  input  logic                 redirect_valid,
  input  logic [31:0]          redirect_pc,
  output logic                 ins_valid,
  output thor_pkg::ins_t       ins
);
  import thor_pkg::*;

  // Fetch side into the queue
  logic               push_valid;
  logic [63:0]        push_data;
  logic [2:0]         push_offset;
  logic               flush;
  // Queue state seen by both the fetch side and the extractor
  logic [COUNT_W-1:0] count;
  logic [63:0]        head;
  logic               pop_valid;
  logic [3:0]         pop_len;

  thor_fetch_ctrl #(
    .QUEUE_BYTES (QUEUE_BYTES),
    .RESET_PC    (RESET_PC)
  ) u_fetch_ctrl (
    .clk             (clk),
    .arst_n          (arst_n),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp       (fetch_rsp),
    .count           (count),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req       (fetch_req),
    .push_valid      (push_valid),
    .push_data       (push_data),
    .push_offset     (push_offset),
    .flush           (flush)
  );

  thor_byte_queue #(
    .QUEUE_BYTES (QUEUE_BYTES)
  ) u_byte_queue (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .push_valid  (push_valid),
    .push_data   (push_data),
    .push_offset (push_offset),
    .pop_valid   (pop_valid),
    .pop_len     (pop_len),
    .count       (count),
    .head        (head)
  );

  thor_ins_extract #(
    .RESET_PC (RESET_PC)
  ) u_ins_extract (
    .clk            (clk),
    .arst_n         (arst_n),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .count          (count),
    .head           (head),
    .pop_valid      (pop_valid),
    .pop_len        (pop_len),
    .ins_valid      (ins_valid),
    .ins            (ins)
  );

endmodule

// ==== tb_thor_align.sv ====
// Testbench for the alignment front end with a memory model, a program table and redirects
`timescale 1ns/10ps

module tb_thor_align;
  import thor_pkg::*;

  localparam logic [31:0] RESET_PC    = 32'h0000_1000;
  localparam int          QUEUE_BYTES = 16;
  localparam int          MEM_BYTES   = 8192;
  localparam int          NSEGS       = 4;
  localparam int          NROWS       = 35;
  // Every row gets a generous eight cycles on top of reset and redirect slack
  localparam int          WATCHDOG_CYCLES = NROWS * 8 + 200;

  // One program row, the segment selects its start address in SEG_PC
  typedef struct packed {
    logic [1:0] seg;
    logic [7:0] op;
    logic [3:0] len;
  } row_t;

  // Segment 0 runs from reset, the others are unaligned redirect targets
  localparam logic [31:0] SEG_PC [NSEGS] = '{
    RESET_PC, 32'h0000_1402, 32'h0000_1806, 32'h0000_1C04
  };

  // Opcode and expected length from the length rule, laid out back to back.
  // Both EXI55 rows of segment 0 start at byte 6 of a fetch word
  localparam row_t PROG [NROWS] = '{
    '{2'd0, ADDI, 4'd4}, '{2'd0, R2, 4'd6}, '{2'd0, NOP, 4'd2}, '{2'd0, LDB, 4'd6},
    '{2'd0, RTS, 4'd2}, '{2'd0, EXI23, 4'd4}, '{2'd0, ADDIL, 4'd6}, '{2'd0, EXI55, 4'd8},
    '{2'd0, STO, 4'd6}, '{2'd0, R1, 4'd4}, '{2'd0, EXI41, 4'd6}, '{2'd0, BEQ, 4'd6},
    '{2'd0, LDOS, 4'd4}, '{2'd0, LDBX, 4'd6}, '{2'd0, EXI7, 4'd2}, '{2'd0, JEQZ, 4'd4},
    '{2'd0, DBNE, 4'd6}, '{2'd0, SYS, 4'd4}, '{2'd0, EXI55, 4'd8}, '{2'd0, STOS, 4'd4},
    '{2'd0, 8'h77, 4'd2}, '{2'd0, MOV, 4'd4}, '{2'd0, XORIL, 4'd6}, '{2'd0, SYNC, 4'd2},
    '{2'd1, EXI55, 4'd8}, '{2'd1, ORI, 4'd4}, '{2'd1, RTE, 4'd2}, '{2'd1, STOX, 4'd6},
    '{2'd2, R3, 4'd6}, '{2'd2, EXI55, 4'd8}, '{2'd2, JNEZ, 4'd4},
    '{2'd3, ANDI, 4'd4}, '{2'd3, LDO, 4'd6}, '{2'd3, 8'h2F, 4'd6}, '{2'd3, NOP, 4'd2}
  };

  logic        clk             = 1'b0;
  logic        arst_n          = 1'b0;
  logic        fetch_req_valid;
  fetch_req_t  fetch_req;
  logic        fetch_rsp_valid = 1'b0;
  fetch_rsp_t  fetch_rsp       = '0;
  logic        redirect_valid  = 1'b0;
  logic [31:0] redirect_pc     = '0;
  logic        ins_valid;
  ins_t        ins;

  // Memory image and expected instruction stream
  logic [7:0]  mem [MEM_BYTES];
  ins_t        exp_tbl [NROWS];
  ins_t        exp_q [$];
  int          seed = 32'hd63848ab;
  int          errors = 0;
  int          checked = 0;
  int          runoff = 0;
  // Memory model state, one request in flight at most
  logic        pending = 1'b0;
  int          wait_cnt = 0;
  logic [31:0] mem_addr = '0;
  logic [31:0] exp_req_addr = {RESET_PC[31:3], 3'b000};
  // Redirect request from the sequence to the bus process
  logic        redir_req = 1'b0;
  int          redir_seg = 0;

  thor_align #(
    .QUEUE_BYTES (QUEUE_BYTES),
    .RESET_PC    (RESET_PC)
  ) uut (
    .clk             (clk),
    .arst_n          (arst_n),
    .fetch_req_valid (fetch_req_valid),
    .fetch_req       (fetch_req),
    .fetch_rsp_valid (fetch_rsp_valid),
    .fetch_rsp       (fetch_rsp),
    .redirect_valid  (redirect_valid),
    .redirect_pc     (redirect_pc),
    .ins_valid       (ins_valid),
    .ins             (ins)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  // ======================================================================
  // Helpers
  // ======================================================================

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  // Fill pattern first, then each segment's rows with random operand bytes
  task automatic build_program();
    logic [31:0] pc;
    logic [31:0] rnd;
    logic [7:0]  byte_v;
    ins_t        e;
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 5);
    end
    for (int s = 0; s < NSEGS; s++) begin
      pc = SEG_PC[s];
      for (int r = 0; r < NROWS; r++) begin
        if (int'(PROG[r].seg) == s) begin
          e     = '0;
          e.pc  = pc;
          e.len = PROG[r].len;
          for (int b = 0; b < int'(PROG[r].len); b++) begin
            rnd    = $random(seed);
            byte_v = (b == 0) ? PROG[r].op : rnd[7:0];
            mem[pc[12:0] + 13'(b)] = byte_v;
            e.bits[b*8 +: 8]      = byte_v;
          end
          exp_tbl[r] = e;
          pc = pc + 32'(PROG[r].len);
        end
      end
    end
  endtask

  task automatic load_expected(input int s);
    for (int r = 0; r < NROWS; r++) begin
      if (int'(PROG[r].seg) == s) begin
        exp_q.push_back(exp_tbl[r]);
      end
    end
  endtask

  // Instructions past a program's end are old stream runoff and only counted
  task automatic check_output();
    ins_t e;
    if (ins_valid) begin
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        check_value("ins.pc", 64'(ins.pc), 64'(e.pc));
        check_value("ins.len", 64'(ins.len), 64'(e.len));
        check_value("ins.bits", ins.bits, e.bits);
        checked++;
      end else begin
        runoff++;
      end
    end
  endtask

  // Answers each request after 1 to 4 cycles and checks the address sequence
  task automatic serve_memory();
    logic [31:0] rnd;
    logic [63:0] data;
    fetch_rsp_valid = 1'b0;
    if (fetch_req_valid) begin
      if (pending) begin
        errors++;
        $display("Second fetch request issued while one is still outstanding at %0t", $time);
      end
      check_value("fetch_req.addr", 64'(fetch_req.addr), 64'(exp_req_addr));
      mem_addr     = fetch_req.addr;
      exp_req_addr = exp_req_addr + 32'd8;
      pending      = 1'b1;
      rnd          = $random(seed);
      wait_cnt     = int'(rnd[1:0]);
    end
    if (pending) begin
      if (wait_cnt == 0) begin
        for (int b = 0; b < FETCH_BYTES; b++) begin
          data[b*8 +: 8] = mem[mem_addr[12:0] + 13'(b)];
        end
        fetch_rsp.data  = data;
        fetch_rsp_valid = 1'b1;
        pending         = 1'b0;
      end else begin
        wait_cnt--;
      end
    end
  endtask

  // Fires only while a request is in flight, so its response goes stale
  task automatic apply_redirect();
    logic [31:0] target;
    redirect_valid = 1'b0;
    if (redir_req && pending && (wait_cnt > 0)) begin
      target         = SEG_PC[redir_seg];
      redirect_valid = 1'b1;
      redirect_pc    = target;
      exp_req_addr   = {target[31:3], 3'b000};
      exp_q.delete();
      load_expected(redir_seg);
      redir_req = 1'b0;
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // ======================================================================
  // Bus process, outputs are checked before the inputs change
  // ======================================================================

  always @(negedge clk) begin
    check_output();
    serve_memory();
    apply_redirect();
  end

  // ======================================================================
  // Sequence
  // ======================================================================

  initial begin
    build_program();
    load_expected(0);
    repeat (16) @(negedge clk);
    check_value("ins_valid", 64'(ins_valid), 64'd0);
    check_value("fetch_req_valid", 64'(fetch_req_valid), 64'd0);
    arst_n = 1'b1;
    wait_drained();
    for (int s = 1; s < NSEGS; s++) begin
      redir_seg = s;
      redir_req = 1'b1;
      while (redir_req) begin
        @(posedge clk);
      end
      wait_drained();
    end
    repeat (4) @(posedge clk);
    $display("Checked %0d instructions, %0d past a program end, %0d errors",
             checked, runoff, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the instruction stream did not finish within %0d cycles",
             WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
thor_pkg.sv
thor_inslength.sv
thor_byte_queue.sv
thor_fetch_ctrl.sv
thor_ins_extract.sv
thor_align.sv
tb_thor_align.sv

// ==== Makefile ====
TOP := tb_thor_align

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o $(TOP)

# The run fails unless the testbench prints the pass line
run: compile
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
